// ==== tests/fft_trace.txt ====
// header: frame count, frame after which the stream breaks, idle cycles of the break
// per frame: 16 input samples, 16 idle cycles before each sample, 16 real bins, 16 imag bins
0005 0002 001E
// frame 0: impulse at position 0
03E8 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8 03E8
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
// frame 1: constant
0064 0064 0064 0064 0064 0064 0064 0064 0064 0064 0064 0064 0064 0064 0064 0064
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0640 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
// frame 2: alternating sign, all energy in bin 8
FFB5 004B FFB5 004B FFB5 004B FFB5 004B FFB5 004B FFB5 004B FFB5 004B FFB5 004B
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 FB50 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
// frame 3: impulse at position 4, with gaps
0000 0000 0000 0000 01F4 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0002 0000 0001 0003 0000 0000 0001 0000 0000 0004 0000 0001 0000 0000 0002 0000
01F4 0000 FE0C 0000 01F4 0000 FE0C 0000 01F4 0000 FE0C 0000 01F4 0000 FE0C 0000
0000 FE0C 0000 01F4 0000 FE0C 0000 01F4 0000 FE0C 0000 01F4 0000 FE0C 0000 01F4
// frame 4: impulse plus negative offset, with gaps
0118 FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC FFEC
0001 0000 0000 0003 0000 0001 0000 0000 0002 0000 0000 0000 0005 0000 0001 0000
FFEC 012C 012C 012C 012C 012C 012C 012C 012C 012C 012C 012C 012C 012C 012C 012C
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// ==== flist.f ====
common/fft_pkg.sv
fft_core/fft_butterfly.sv
fft_core/fft_stage_schedule.sv
fft_core/fft_core.sv
verilog/sample_deserializer.sv
verilog/spectrum_output.sv
verilog/stream_end_detect.sv
verilog/fft_top.sv
tests/fft_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module fft_tb -f flist.f -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/Vfft_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/fft_tb.sv ====
`timescale 1ns/1ps

module fft_tb;

    localparam int HDR_WORDS    = 3;
    localparam int FRAME_WORDS  = 4 * fft_pkg::N_POINTS;
    localparam int MAX_FRAMES   = 8;
    localparam int TRACE_WORDS  = HDR_WORDS + MAX_FRAMES * FRAME_WORDS;
    // edge that takes the 16th sample to the first fft_valid cycle
    localparam int LATENCY      = 6;
    localparam int RESET_CYCLES = 8;

    logic                                     clk = 1'b0;
    logic                                     rst;
    fft_pkg::sample_t                         fir_d;
    logic                                     fir_valid;
    logic                                     fft_valid;
    fft_pkg::sample_t [fft_pkg::N_POINTS-1:0] fft_d;
    logic                                     done;

    logic [15:0]        trace_mem [TRACE_WORDS];
    fft_pkg::spectrum_t exp_spec [MAX_FRAMES];
    int                 n_frames;
    int                 break_frame;
    int                 break_idle;

    int cyc;
    int cycle_limit;
    int frames_seen;
    // cycle of the first fft_valid for each frame in flight
    int first_q [$];

    // end-of-stream model
    logic fir_at_edge;
    logic fir_prev_m;
    logic armed_m;
    logic efv_d1;
    logic efv_d2;

    fft_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .fir_d     (fir_d),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .fft_d     (fft_d),
        .done      (done)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_bins(
        input fft_pkg::sample_t [fft_pkg::N_POINTS-1:0] got,
        input fft_pkg::sample_t [fft_pkg::N_POINTS-1:0] want,
        input string                                    half,
        input int                                       frame
    );
        for (int j = 0; j < fft_pkg::N_POINTS; j++) begin
            if (got[j] !== want[j]) begin
                $display("Mismatch at %0t: frame %0d %s bin %0d is %0d, expected %0d",
                         $time, frame, half, j, got[j], want[j]);
                abort_run();
            end
        end
    endtask

    task automatic check_valid(input logic got, input logic want);
        if (got !== want) begin
            $display("Mismatch at %0t: fft_valid is %b, expected %b in cycle %0d",
                     $time, got, want, cyc);
            abort_run();
        end
    endtask

    task automatic check_done(input logic got, input logic want);
        if (got !== want) begin
            $display("Mismatch at %0t: done is %b, expected %b in cycle %0d",
                     $time, got, want, cyc);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // trace and stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_trace();
        int base;
        $readmemh("tests/fft_trace.txt", trace_mem);
        n_frames    = int'(trace_mem[0]);
        break_frame = int'(trace_mem[1]);
        break_idle  = int'(trace_mem[2]);
        if (n_frames < 1 || n_frames > MAX_FRAMES || break_frame >= n_frames) begin
            $display("The trace file header does not give a usable frame count or break");
            abort_run();
        end
        cycle_limit = RESET_CYCLES + break_idle + 20 * n_frames;
        for (int f = 0; f < n_frames; f++) begin
            base = HDR_WORDS + f * FRAME_WORDS;
            for (int j = 0; j < fft_pkg::N_POINTS; j++) begin
                cycle_limit += 1 + int'(trace_mem[base + fft_pkg::N_POINTS + j]);
                exp_spec[f].re[j] = fft_pkg::sample_t'(trace_mem[base + 2 * fft_pkg::N_POINTS + j]);
                exp_spec[f].im[j] = fft_pkg::sample_t'(trace_mem[base + 3 * fft_pkg::N_POINTS + j]);
            end
        end
    endtask

    // called on a falling edge; each sample is taken at the next rising edge
    task automatic drive_frame(input int f);
        int base;
        base = HDR_WORDS + f * FRAME_WORDS;
        for (int k = 0; k < fft_pkg::N_POINTS; k++) begin
            for (int g = 0; g < int'(trace_mem[base + fft_pkg::N_POINTS + k]); g++) begin
                fir_valid = 1'b0;
                @(negedge clk);
            end
            fir_valid = 1'b1;
            fir_d     = fft_pkg::sample_t'(trace_mem[base + k]);
            if (k == fft_pkg::N_POINTS - 1) begin
                first_q.push_back(cyc + 1 + LATENCY);
            end
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cyc         <= cyc + 1;
        fir_at_edge <= fir_valid;
        if (cyc > cycle_limit) begin
            $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
            abort_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic efv;
        logic exp_done;
        logic fir_fall;
        logic fft_fall;
        if (rst) begin
            fir_prev_m = 1'b0;
            armed_m    = 1'b0;
            efv_d1     = 1'b0;
            efv_d2     = 1'b0;
        end else begin
            // a fall of fir_valid arms, the next fall of fft_valid fires done
            fir_fall = fir_prev_m && !fir_at_edge;
            fft_fall = efv_d2 && !efv_d1;
            exp_done = armed_m && fft_fall;
            if (fir_fall) begin
                armed_m = 1'b1;
            end
            if (exp_done) begin
                armed_m = 1'b0;
            end
            fir_prev_m = fir_at_edge;
            check_done(done, exp_done);

            efv = (first_q.size() > 0) && (cyc == first_q[0] || cyc == first_q[0] + 1);
            check_valid(fft_valid, efv);
            if (efv && cyc == first_q[0]) begin
                check_bins(fft_d, exp_spec[frames_seen].re, "real", frames_seen);
            end else if (efv) begin
                check_bins(fft_d, exp_spec[frames_seen].im, "imag", frames_seen);
                first_q.delete(0);
                frames_seen++;
            end
            efv_d2 = efv_d1;
            efv_d1 = efv;
        end
    end

    initial begin
        rst         = 1'b1;
        fir_valid   = 1'b0;
        fir_d       = '0;
        cyc         = 0;
        frames_seen = 0;
        cycle_limit = 1000;
        load_trace();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int f = 0; f < n_frames; f++) begin
            drive_frame(f);
            if (f == break_frame) begin
                fir_valid = 1'b0;
                repeat (break_idle) @(negedge clk);
            end
        end
        fir_valid = 1'b0;

        // drain until the last pair is out and its done has been checked
        while (!(frames_seen == n_frames && !armed_m)) begin
            @(posedge clk);
        end
        @(posedge clk);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== verilog/fft_top.sv ====
`timescale 1ns/1ps

module fft_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  fft_pkg::sample_t                       fir_d,
    input  logic                                   fir_valid,
    output logic                                   fft_valid,
    output fft_pkg::sample_t [fft_pkg::N_POINTS-1:0] fft_d,
    output logic                                   done
);

    fft_pkg::frame_t    frame;
    logic               frame_ready;
    fft_pkg::spectrum_t spectrum;
    logic               fft_done;

    sample_deserializer u_deser (
        .clk         (clk),
        .rst         (rst),
        .fir_d       (fir_d),
        .fir_valid   (fir_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    fft_core u_core (
        .clk         (clk),
        .rst         (rst),
        .frame       (frame),
        .frame_ready (frame_ready),
        .spectrum    (spectrum),
        .fft_done    (fft_done)
    );

    spectrum_output u_out (
        .clk       (clk),
        .rst       (rst),
        .spectrum  (spectrum),
        .fft_done  (fft_done),
        .fft_valid (fft_valid),
        .fft_d     (fft_d)
    );

    stream_end_detect u_end (
        .clk       (clk),
        .rst       (rst),
        .fir_valid (fir_valid),
        .fft_valid (fft_valid),
        .done      (done)
    );

endmodule

// ==== verilog/stream_end_detect.sv ====
`timescale 1ns/1ps

module stream_end_detect (
    input  logic clk,
    input  logic rst,
    input  logic fir_valid,
    input  logic fft_valid,
    output logic done
);

    logic fir_prev;
    logic fft_prev;
    // input has stopped, waiting for the output to drain
    logic armed;

    logic fir_fall;
    logic fft_fall;

    assign fir_fall = fir_prev & ~fir_valid;
    assign fft_fall = fft_prev & ~fft_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fir_prev <= 1'b0;
            fft_prev <= 1'b0;
            armed    <= 1'b0;
            done     <= 1'b0;
        end else begin
            fir_prev <= fir_valid;
            fft_prev <= fft_valid;
            done     <= 1'b0;
            if (fir_fall) begin
                armed <= 1'b1;
            end
            if (armed && fft_fall) begin
                done  <= 1'b1;
                armed <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/spectrum_output.sv ====
`timescale 1ns/1ps

module spectrum_output (
    input  logic                                   clk,
    input  logic                                   rst,
    input  fft_pkg::spectrum_t                     spectrum,
    input  logic                                   fft_done,
    output logic                                   fft_valid,
    output fft_pkg::sample_t [fft_pkg::N_POINTS-1:0] fft_d
);

    logic done_d1;
    logic done_d2;
    // 0 = real half next
    logic phase;
    logic send;

    assign send = fft_done | done_d1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done_d1 <= 1'b0;
            done_d2 <= 1'b0;
            phase   <= 1'b0;
        end else begin
            done_d1 <= fft_done;
            done_d2 <= done_d1;
            if (send) begin
                phase <= ~phase;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output word, real half then imag half
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (send) begin
            fft_d <= phase ? spectrum.im : spectrum.re;
        end
    end

    assign fft_valid = done_d1 | done_d2;

    a_valid_pair: assert property (@(posedge clk) disable iff (rst)
        $rose(fft_valid) |=> fft_valid ##1 !fft_valid);

endmodule

// ==== verilog/sample_deserializer.sv ====
`timescale 1ns/1ps

module sample_deserializer (
    input  logic             clk,
    input  logic             rst,
    input  fft_pkg::sample_t fir_d,
    input  logic             fir_valid,
    output fft_pkg::frame_t  frame,
    output logic             frame_ready
);

    // next write position, wraps after the last point
    fft_pkg::idx_t pos;

    logic last_pos;

    assign last_pos = (pos == fft_pkg::idx_t'(fft_pkg::N_POINTS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // position counter and ready strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos         <= '0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= fir_valid && last_pos;
            if (fir_valid) begin
                pos <= pos + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sample store
    ////////////////////////////////////////////////////////////////////////////

    // sign extend, then move up into the internal word
    always_ff @(posedge clk) begin
        if (fir_valid) begin
            frame[pos] <= fft_pkg::acc_t'(fir_d) <<< fft_pkg::IN_SHIFT;
        end
    end

endmodule

// ==== fft_core/fft_core.sv ====
`timescale 1ns/1ps

module fft_core (
    input  logic               clk,
    input  logic               rst,
    input  fft_pkg::frame_t    frame,
    input  logic               frame_ready,
    output fft_pkg::spectrum_t spectrum,
    output logic               fft_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_STAGE1,
        ST_STAGE2,
        ST_STAGE3,
        ST_STAGE4,
        ST_DONE
    } state_t;

    state_t state;
    state_t op;
    state_t state_next;

    logic [$clog2(fft_pkg::N_STAGES)-1:0] stage;
    logic                                 stage_active;

    // ping-pong buffers
    fft_pkg::cplx_t buf_a [fft_pkg::N_POINTS];
    fft_pkg::cplx_t buf_b [fft_pkg::N_POINTS];

    fft_pkg::idx_t  [fft_pkg::N_BFLY-1:0] idx_a;
    fft_pkg::idx_t  [fft_pkg::N_BFLY-1:0] idx_b;
    fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] w;
    fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] bf_x;
    fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] bf_y;
    fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] bf_sum;
    fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] bf_diff;

    function automatic fft_pkg::idx_t bit_rev(input fft_pkg::idx_t i);
        fft_pkg::idx_t r;
        for (int b = 0; b < $bits(fft_pkg::idx_t); b++) begin
            r[b] = i[$bits(fft_pkg::idx_t)-1-b];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stage FSM
    ////////////////////////////////////////////////////////////////////////////

    // load happens in the idle cycle that sees the strobe
    always_comb begin
        op = state;
        if (state == ST_IDLE && frame_ready) begin
            op = ST_LOAD;
        end
    end

    always_comb begin
        case (op)
            ST_LOAD:   state_next = ST_STAGE1;
            ST_STAGE1: state_next = ST_STAGE2;
            ST_STAGE2: state_next = ST_STAGE3;
            ST_STAGE3: state_next = ST_STAGE4;
            ST_STAGE4: state_next = ST_DONE;
            default:   state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        stage_active = 1'b1;
        case (state)
            ST_STAGE1: stage = 2'd0;
            ST_STAGE2: stage = 2'd1;
            ST_STAGE3: stage = 2'd2;
            ST_STAGE4: stage = 2'd3;
            default: begin
                stage        = 2'd0;
                stage_active = 1'b0;
            end
        endcase
    end

    assign fft_done = (state == ST_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // butterfly array
    ////////////////////////////////////////////////////////////////////////////

    fft_stage_schedule u_sched (
        .stage (stage),
        .idx_a (idx_a),
        .idx_b (idx_b),
        .w     (w)
    );

    // odd stage numbers (2 and 4) read B
    for (genvar k = 0; k < fft_pkg::N_BFLY; k++) begin : g_bfly
        assign bf_x[k] = stage[0] ? buf_b[idx_a[k]] : buf_a[idx_a[k]];
        assign bf_y[k] = stage[0] ? buf_b[idx_b[k]] : buf_a[idx_b[k]];

        fft_butterfly u_bfly (
            .x    (bf_x[k]),
            .y    (bf_y[k]),
            .w    (w[k]),
            .sum  (bf_sum[k]),
            .diff (bf_diff[k])
        );
    end

    // results go back to the pair they came from, in the other buffer
    always_ff @(posedge clk) begin
        if (op == ST_LOAD) begin
            for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
                buf_a[i].re <= frame[i];
                buf_a[i].im <= '0;
            end
        end else if (stage_active) begin
            for (int k = 0; k < fft_pkg::N_BFLY; k++) begin
                if (stage[0]) begin
                    buf_a[idx_a[k]] <= bf_sum[k];
                    buf_a[idx_b[k]] <= bf_diff[k];
                end else begin
                    buf_b[idx_a[k]] <= bf_sum[k];
                    buf_b[idx_b[k]] <= bf_diff[k];
                end
            end
        end
    end

    // final results sit in A in bit-reversed order
    always_comb begin
        for (int j = 0; j < fft_pkg::N_POINTS; j++) begin
            spectrum.re[j] = buf_a[bit_rev(fft_pkg::idx_t'(j))].re[fft_pkg::IN_SHIFT +:
                                                                   fft_pkg::SAMPLE_W];
            spectrum.im[j] = buf_a[bit_rev(fft_pkg::idx_t'(j))].im[fft_pkg::IN_SHIFT +:
                                                                   fft_pkg::SAMPLE_W];
        end
    end

    a_frame_when_idle: assert property (@(posedge clk) disable iff (rst)
        frame_ready |-> state == ST_IDLE);

    // load, four stages, then a single done cycle
    a_done_after_frame: assert property (@(posedge clk) disable iff (rst)
        frame_ready |-> ##5 fft_done ##1 !fft_done);

endmodule

// ==== fft_core/fft_stage_schedule.sv ====
`timescale 1ns/1ps

module fft_stage_schedule (
    input  logic [$clog2(fft_pkg::N_STAGES)-1:0] stage,
    output fft_pkg::idx_t  [fft_pkg::N_BFLY-1:0] idx_a,
    output fft_pkg::idx_t  [fft_pkg::N_BFLY-1:0] idx_b,
    output fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] w
);

    ////////////////////////////////////////////////////////////////////////////
    // twiddle table, cos and -sin of 2*pi*k/16 in Q16
    ////////////////////////////////////////////////////////////////////////////

    localparam fft_pkg::acc_t TW_RE [fft_pkg::N_BFLY] = '{
        32'sh0001_0000,
        32'sh0000_EC83,
        32'sh0000_B504,
        32'sh0000_61F7,
        32'sh0000_0000,
        -32'sh0000_61F7,
        -32'sh0000_B504,
        -32'sh0000_EC83
    };

    localparam fft_pkg::acc_t TW_IM [fft_pkg::N_BFLY] = '{
        32'sh0000_0000,
        -32'sh0000_61F7,
        -32'sh0000_B504,
        -32'sh0000_EC83,
        -32'sh0001_0000,
        -32'sh0000_EC83,
        -32'sh0000_B504,
        -32'sh0000_61F7
    };

    ////////////////////////////////////////////////////////////////////////////
    // pair and twiddle schedule
    ////////////////////////////////////////////////////////////////////////////

    // stride halves every stage; twiddle step doubles
    always_comb begin
        int               stride;
        int               offset;
        int               base;
        fft_pkg::tw_idx_t tw;
        stride = fft_pkg::N_BFLY >> stage;
        for (int k = 0; k < fft_pkg::N_BFLY; k++) begin
            offset   = k & (stride - 1);
            base     = (k & ~(stride - 1)) << 1;
            idx_a[k] = fft_pkg::idx_t'(base + offset);
            idx_b[k] = fft_pkg::idx_t'(base + offset + stride);
            tw       = fft_pkg::tw_idx_t'(offset << stage);
            w[k].re  = TW_RE[tw];
            w[k].im  = TW_IM[tw];
        end
    end

endmodule

// ==== fft_core/fft_butterfly.sv ====
`timescale 1ns/1ps

module fft_butterfly (
    input  fft_pkg::cplx_t x,
    input  fft_pkg::cplx_t y,
    input  fft_pkg::cplx_t w,
    output fft_pkg::cplx_t sum,
    output fft_pkg::cplx_t diff
);

    fft_pkg::acc_t d_re;
    fft_pkg::acc_t d_im;
    fft_pkg::acc_t nd_im;

    logic signed [2*fft_pkg::ACC_W-1:0] p_rr;
    logic signed [2*fft_pkg::ACC_W-1:0] p_ii;
    logic signed [2*fft_pkg::ACC_W-1:0] p_ri;
    logic signed [2*fft_pkg::ACC_W-1:0] p_ir;

    assign sum.re = x.re + y.re;
    assign sum.im = x.im + y.im;

    assign d_re  = x.re - y.re;
    assign d_im  = x.im - y.im;
    // negated, so the imag product is truncated after the sign flip
    assign nd_im = y.im - x.im;

    assign p_rr = d_re * w.re;
    assign p_ii = nd_im * w.im;
    assign p_ri = d_re * w.im;
    assign p_ir = d_im * w.re;

    // Q16 products, keep bits 47:16
    assign diff.re = p_rr[fft_pkg::FRAC_W +: fft_pkg::ACC_W]
                   + p_ii[fft_pkg::FRAC_W +: fft_pkg::ACC_W];
    assign diff.im = p_ri[fft_pkg::FRAC_W +: fft_pkg::ACC_W]
                   + p_ir[fft_pkg::FRAC_W +: fft_pkg::ACC_W];

endmodule

// ==== common/fft_pkg.sv ====
package fft_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // transform size
    ////////////////////////////////////////////////////////////////////////////

    localparam int N_POINTS = 16;
    localparam int N_STAGES = 4;
    localparam int N_BFLY   = 8;

    ////////////////////////////////////////////////////////////////////////////
    // fixed-point formats
    ////////////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 16;
    localparam int ACC_W    = 32;
    // twiddles are Q16
    localparam int FRAC_W   = 16;
    // sample sits at bits 23:8 of the internal word
    localparam int IN_SHIFT = 8;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    typedef logic [3:0] idx_t;
    typedef logic [2:0] tw_idx_t;

    typedef struct packed {
        acc_t re;
        acc_t im;
    } cplx_t;

    // one frame of real samples, indexed by sample position
    typedef acc_t [N_POINTS-1:0] frame_t;

    // bins in natural order
    typedef struct packed {
        sample_t [N_POINTS-1:0] re;
        sample_t [N_POINTS-1:0] im;
    } spectrum_t;

endpackage
